// File: sources.f
rtl/cart_pkg.sv
rtl/cart_header.sv
rtl/mbc_regs.sv
rtl/cart_ram.sv
rtl/backup_fsm.sv
rtl/sector_counter.sv
rtl/cart_top.sv
test/cart_checker.sv
test/cart_tb.sv

// File: Makefile
# verilator build and run of the cartridge mapper testbench

SIM  := obj_dir/cart_sim
SRCS := $(wildcard rtl/*.sv test/*.sv)

.PHONY: all run clean

all: run

$(SIM): sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module cart_tb \
		-f sources.f --Mdir obj_dir -o cart_sim

run: $(SIM)
	$(SIM) +verilator+error+limit+100 > sim.log 2>&1
	@cat sim.log
	@if grep -q "Finished with errors" sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: test/cart_tb.sv
// testbench of the cartridge mapper core with header decode, banking, ram rules and backups
`timescale 1ns/1ns

module cart_tb;

	localparam int words_per_file = 1024;      // ram size 1 gives four 512-byte sectors
	localparam int sector_cycles  = 256 + 16;  // ack delay, stream, fsm turnaround
	localparam int timeout_cycles = 8 * 4 * sector_cycles + 2 * 2048 + 2000;

	logic                 clk_sys;
	logic                 reset;
	cart_pkg::cpu_addr_u  cart_addr_i;
	logic                 cart_rd_i;
	logic                 cart_wr_i;
	logic [7:0]           cart_di_i;
	logic [22:0]          rom_addr_o;
	logic [7:0]           cart_do_o;
	logic                 dl_active_i;
	logic                 dl_wr_i;
	logic [24:0]          dl_addr_i;
	logic [15:0]          dl_data_i;
	logic                 img_mounted_i;
	logic                 img_readonly_i;
	logic                 img_nonzero_i;
	logic                 load_req_i;
	logic                 save_req_i;
	logic                 osd_status_i;
	logic                 autosave_en_i;
	logic                 sd_rd_o;
	logic                 sd_wr_o;
	logic [7:0]           sd_lba_o;
	logic                 sd_ack_i;
	logic [7:0]           sd_buff_addr_i;
	logic [15:0]          sd_buff_dout_i;
	logic [15:0]          sd_buff_din_o;
	logic                 sd_buff_wr_i;
	logic                 busy_o;
	logic                 sav_pending_o;

	logic [31:0] lfsr;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          cycles = 0;
	logic [7:0]  ram_bytes [2 * words_per_file];  // what the cpu wrote
	logic [15:0] src_words [words_per_file];      // image served on loads
	logic [15:0] saved_words [words_per_file];    // image captured on saves
	logic [7:0]  save_log [$];                    // sector index per save sector
	logic [7:0]  load_log [$];

	cart_top uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// run limit counted in cycles from time 0
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout: the run did not end within %0d cycles", timeout_cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	function automatic logic lfsr_bit();
		logic fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32 22 2 1
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] lfsr_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
			v = {v[14:0], lfsr_bit()};
		return v;
	endfunction

	task automatic tick();
		@(posedge clk_sys);
		#1;  // drive and sample just after the edge
	endtask

	task automatic check_value(input string test, input string what,
			input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp)
		else begin
			$display("FAILED %s, %s: expected %h, actual %h", test, what, exp, act);
			errors++;
		end
	endtask

	task automatic end_test(input string test, input int first_err);
		tests++;
		$display("test %0d %s done, %0d errors", tests, test, errors - first_err);
	endtask

	task automatic download_header(input logic [7:0] kind, input logic [7:0] rom_size,
			input logic [7:0] ram_size, input logic mounted);
		img_mounted_i = mounted;
		dl_active_i   = 1'b1;
		tick();
		dl_addr_i = 25'(cart_pkg::hdr_type_addr);
		dl_data_i = {kind, 8'h00};          // type sits in the high byte
		dl_wr_i   = 1'b1;
		tick();
		dl_addr_i = 25'(cart_pkg::hdr_size_addr);
		dl_data_i = {ram_size, rom_size};
		tick();
		dl_wr_i = 1'b0;
		tick();
		dl_active_i = 1'b0;
		tick();                             // bank registers released
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		cart_addr_i = addr;
		cart_di_i   = data;
		cart_wr_i   = 1'b1;
		tick();
		cart_wr_i = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
		cart_addr_i = addr;
		cart_rd_i   = 1'b1;
		tick();
		cart_rd_i = 1'b0;
		data      = cart_do_o;  // one cycle after the read pulse
	endtask

	task automatic rom_addr_at(input logic [15:0] addr, output logic [22:0] ra);
		cart_addr_i = addr;
		tick();
		ra = rom_addr_o;
	endtask

	// the trigger is already driven and busy follows one cycle later
	task automatic wait_transfer(input string test);
		tick();
		check_value(test, "busy after trigger", 32'd1, 32'(busy_o));
		while (busy_o)
			tick();
	endtask

	// ------------------------------------------------------------------------
	// storage model acks a few cycles after a request and streams 256 words
	// ------------------------------------------------------------------------
	initial begin : storage_model
		logic       is_load;
		logic [7:0] lba;
		int         idx;
		sd_ack_i       = 1'b0;
		sd_buff_addr_i = '0;
		sd_buff_dout_i = '0;
		sd_buff_wr_i   = 1'b0;
		forever begin
			tick();
			if (sd_rd_o || sd_wr_o) begin
				is_load = sd_rd_o;
				repeat (3) tick();
				lba = sd_lba_o;
				if (is_load)
					load_log.push_back(lba);
				else
					save_log.push_back(lba);
				sd_ack_i = 1'b1;
				for (int i = 0; i < 256; i++) begin
					idx            = int'(lba) * 256 + i;
					sd_buff_addr_i = 8'(i);
					sd_buff_wr_i   = is_load;
					sd_buff_dout_i = (is_load && idx < words_per_file) ? src_words[idx] : 16'h0;
					tick();
					if (!is_load && idx < words_per_file)
						saved_words[idx] = sd_buff_din_o;  // din follows addr by one cycle
				end
				sd_buff_wr_i = 1'b0;
				sd_ack_i     = 1'b0;  // sector done
			end
		end
	end

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	initial begin
		logic [22:0] ra;
		logic [7:0]  rd;
		logic [8:0]  bank;
		logic [12:0] offs [8];
		logic [7:0]  data [8];
		logic [10:0] boff;
		logic [15:0] word;
		int          first_err;
		reset          = 1'b1;
		cart_addr_i    = '0;
		cart_rd_i      = 1'b0;
		cart_wr_i      = 1'b0;
		cart_di_i      = '0;
		dl_active_i    = 1'b0;
		dl_wr_i        = 1'b0;
		dl_addr_i      = '0;
		dl_data_i      = '0;
		img_mounted_i  = 1'b0;
		img_readonly_i = 1'b0;
		img_nonzero_i  = 1'b0;  // no reload at the end of a download
		load_req_i     = 1'b0;
		save_req_i     = 1'b0;
		osd_status_i   = 1'b0;
		autosave_en_i  = 1'b0;
		lfsr           = 32'h86304dd9;
		repeat (16) tick();
		reset = 1'b0;
		tick();

		// mbc1, rom size 4 (mask 31), ram size 3
		first_err = errors;
		download_header(8'h01, 8'd4, 8'd3, 1'b0);
		cpu_write(16'h2000, 8'h00);  // bank 0 is stored as 1
		rom_addr_at(16'h4123, ra);
		check_value("mbc1", "bank 0 written", 32'({9'd1, 14'h0123}), 32'(ra));
		cpu_write(16'h2000, 8'h3F);
		bank = 9'h03F & 9'((1 << (4 + 1)) - 1);
		rom_addr_at(16'h7FFE, ra);
		check_value("mbc1", "bank 3f masked", 32'({bank, 14'h3FFE}), 32'(ra));
		rom_addr_at(16'h1234, ra);
		check_value("mbc1", "quadrant 0", 32'({9'd0, 14'h1234}), 32'(ra));
		end_test("mbc1 banking", first_err);

		// mbc5, rom size 8, nine bank bits
		first_err = errors;
		download_header(8'h19, 8'd8, 8'd0, 1'b0);
		cpu_write(16'h3000, 8'h01);  // bank bit 8
		cpu_write(16'h2000, 8'h5A);
		bank = 9'h15A & 9'((1 << (8 + 1)) - 1);
		rom_addr_at(16'h7ABC, ra);
		check_value("mbc5", "bank 15a", 32'({bank, 14'h3ABC}), 32'(ra));
		rom_addr_at(16'h2ABC, ra);
		check_value("mbc5", "quadrant 0", 32'({9'd0, 14'h2ABC}), 32'(ra));
		end_test("mbc5 banking", first_err);

		// ram enable, random bytes in distinct 1k blocks, mbc2 nibbles
		first_err = errors;
		download_header(8'h03, 8'd1, 8'd3, 1'b0);
		cpu_read(16'hA000, rd);
		check_value("ram", "read while disabled", 32'hFF, 32'(rd));
		cpu_write(16'h0000, 8'h0A);
		for (int k = 0; k < 8; k++) begin
			offs[k] = {3'(k), 10'(lfsr_bits(10))};
			data[k] = 8'(lfsr_bits(8));
			cpu_write(16'hA000 | 16'(offs[k]), data[k]);
		end
		for (int k = 0; k < 8; k++) begin
			cpu_read(16'hA000 | 16'(offs[k]), rd);
			check_value("ram", $sformatf("read %h", 16'hA000 | 16'(offs[k])),
				32'(data[k]), 32'(rd));
		end
		download_header(8'h06, 8'd1, 8'd0, 1'b0);  // mbc2 with battery
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'hA010, 8'h5C);
		cpu_read(16'hA010, rd);
		check_value("ram", "mbc2 nibble", 32'hFC, 32'(rd));
		end_test("ram rules", first_err);

		// save of a battery cartridge with ram size 1 and file mask 3
		first_err = errors;
		download_header(8'h03, 8'd1, 8'd1, 1'b1);  // image mounted writable
		cpu_write(16'h0000, 8'h0A);
		for (int b = 0; b < 2 * words_per_file; b++) begin
			ram_bytes[b] = 8'(lfsr_bits(8));
			cpu_write(16'hA000 + 16'(b), ram_bytes[b]);
		end
		save_log.delete();
		save_req_i = 1'b1;
		wait_transfer("save");
		save_req_i = 1'b0;
		check_value("save", "sector count", 32'(3 + 1), 32'(save_log.size()));
		foreach (save_log[k])
			check_value("save", $sformatf("sector %0d index", k), 32'(k), 32'(save_log[k]));
		for (int w = 0; w < words_per_file; w++)
			check_value("save", $sformatf("word %0d", w),
				32'({ram_bytes[2 * w + 1], ram_bytes[2 * w]}), 32'(saved_words[w]));
		check_value("save", "pending after save", 32'd0, 32'(sav_pending_o));
		end_test("save", first_err);

		// load from the model, then autosave when the osd opens
		first_err = errors;
		for (int w = 0; w < words_per_file; w++)
			src_words[w] = lfsr_bits(16);
		load_log.delete();
		load_req_i = 1'b1;
		wait_transfer("load");
		load_req_i = 1'b0;
		check_value("load", "sector count", 32'(3 + 1), 32'(load_log.size()));
		for (int k = 0; k < 16; k++) begin
			boff = 11'(lfsr_bits(11));
			word = src_words[boff[10:1]];  // odd byte in the high lane
			cpu_read(16'hA000 | 16'(boff), rd);
			check_value("load", $sformatf("read %h", 16'hA000 | 16'(boff)),
				32'(boff[0] ? word[15:8] : word[7:0]), 32'(rd));
		end
		check_value("autosave", "pending before write", 32'd0, 32'(sav_pending_o));
		cpu_write(16'hA000, 8'h11);
		check_value("autosave", "pending after write", 32'd1, 32'(sav_pending_o));
		save_log.delete();
		osd_status_i  = 1'b1;
		autosave_en_i = 1'b1;
		wait_transfer("autosave");
		check_value("autosave", "pending after save", 32'd0, 32'(sav_pending_o));
		check_value("autosave", "sector count", 32'(3 + 1), 32'(save_log.size()));
		osd_status_i  = 1'b0;
		autosave_en_i = 1'b0;
		end_test("load and autosave", first_err);

		$display("%0d tests, %0d checks, %0d errors, %0d checker failures",
			tests, checks, errors, uut.u_checker.fail_count);
		if (errors == 0 && uut.u_checker.fail_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: test/cart_checker.sv
// storage handshake and reset state checks for the cartridge mapper core
`timescale 1ns/1ns

module cart_checker (
	input logic clk_sys,
	input logic reset,
	input logic sd_rd_i,
	input logic sd_wr_i,
	input logic sd_ack_i,
	input logic busy_i,
	input logic sav_pending_i
);

	int fail_count = 0;  // read by the testbench at the end of the run

	// ------------------------------------------------------------------------
	// storage port handshake
	// ------------------------------------------------------------------------
	rw_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd_i && sd_wr_i))
	else begin
		$error("storage read and write requests are high together");
		fail_count++;
	end

	// a request never stands outside a transfer
	req_in_busy: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd_i || sd_wr_i) |-> busy_i)
	else begin
		$error("storage request is high while the core is not busy");
		fail_count++;
	end

	req_drop: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(sd_ack_i) |=> !(sd_rd_i || sd_wr_i))  // level drops right after ack
	else begin
		$error("storage request did not fall one cycle after ack rose");
		fail_count++;
	end

	// ------------------------------------------------------------------------
	// reset state
	// ------------------------------------------------------------------------
	reset_quiet: assert property (@(posedge clk_sys)
		reset |=> !sd_rd_i && !sd_wr_i && !busy_i && !sav_pending_i)
	else begin
		$error("backup outputs are not low during reset");
		fail_count++;
	end

endmodule

bind cart_top cart_checker u_checker (
	.clk_sys       (clk_sys),
	.reset         (reset),
	.sd_rd_i       (sd_rd_o),
	.sd_wr_i       (sd_wr_o),
	.sd_ack_i      (sd_ack_i),
	.busy_i        (busy_o),
	.sav_pending_i (sav_pending_o)
);

// File: rtl/cart_top.sv
// cartridge mapper core top: header decode, bank registers, cartridge ram and backup transfers
`timescale 1ns/1ns

module cart_top (
	input  logic                                clk_sys,
	input  logic                                reset,
	// cpu port
	input  cart_pkg::cpu_addr_u                 cart_addr_i,
	input  logic                                cart_rd_i,
	input  logic                                cart_wr_i,
	input  logic [7:0]                          cart_di_i,
	output logic [cart_pkg::rom_bank_w+13:0]    rom_addr_o,
	output logic [7:0]                          cart_do_o,
	// download and image status
	input  logic                                dl_active_i,
	input  logic                                dl_wr_i,
	input  logic [24:0]                         dl_addr_i,
	input  logic [15:0]                         dl_data_i,
	input  logic                                img_mounted_i,
	input  logic                                img_readonly_i,
	input  logic                                img_nonzero_i,
	// backup requests
	input  logic                                load_req_i,
	input  logic                                save_req_i,
	input  logic                                osd_status_i,
	input  logic                                autosave_en_i,
	// storage port
	output logic                                sd_rd_o,
	output logic                                sd_wr_o,
	output logic [cart_pkg::lba_w-1:0]          sd_lba_o,
	input  logic                                sd_ack_i,
	input  logic [7:0]                          sd_buff_addr_i,
	input  logic [15:0]                         sd_buff_dout_i,
	output logic [15:0]                         sd_buff_din_o,
	input  logic                                sd_buff_wr_i,
	output logic                                busy_o,
	output logic                                sav_pending_o
);

	cart_pkg::cart_info_t              info;
	cart_pkg::bank_state_t             bank;
	logic [cart_pkg::cram_addr_w-1:0]  cram_addr;
	logic                              cram_wr;
	logic                              start;
	logic                              step;
	logic                              last;

	// cpu write into a000-bfff
	assign cram_wr = cart_wr_i && (cart_addr_i.rgn.region == cart_pkg::region_cram);

	cart_header u_header (
		.clk_sys, .reset, .dl_active_i, .dl_wr_i, .dl_addr_i, .dl_data_i,
		.info_o (info)
	);

	mbc_regs u_regs (
		.clk_sys, .reset, .dl_active_i, .cart_addr_i, .cart_wr_i, .cart_di_i,
		.info_i      (info),
		.bank_o      (bank),
		.rom_addr_o,
		.cram_addr_o (cram_addr)
	);

	cart_ram u_ram (
		.clk_sys, .cart_addr_i, .cart_rd_i,
		.cart_wr_i   (cram_wr),
		.cart_di_i,
		.cram_addr_i (cram_addr),
		.bank_i      (bank),
		.info_i      (info),
		.sd_buff_addr_i,
		.sd_lba_i    (sd_lba_o),
		.sd_buff_dout_i, .sd_buff_wr_i, .sd_ack_i, .cart_do_o, .sd_buff_din_o
	);

	backup_fsm u_fsm (
		.clk_sys, .reset, .dl_active_i, .img_mounted_i, .img_readonly_i, .img_nonzero_i,
		.load_req_i, .save_req_i, .osd_status_i, .autosave_en_i,
		.cram_wr_i (cram_wr),
		.info_i    (info),
		.sd_ack_i,
		.last_i    (last),
		.sd_rd_o, .sd_wr_o, .busy_o, .sav_pending_o,
		.start_o   (start),
		.step_o    (step)
	);

	sector_counter u_lba (
		.clk_sys, .reset,
		.start_i     (start),
		.step_i      (step),
		.file_mask_i (info.file_mask),
		.lba_o       (sd_lba_o),
		.last_o      (last)
	);

endmodule

// File: rtl/sector_counter.sv
// sector index of a backup transfer and last sector detect
`timescale 1ns/1ns

module sector_counter (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        start_i,
	input  logic                        step_i,
	input  logic [cart_pkg::lba_w-1:0]  file_mask_i,
	output logic [cart_pkg::lba_w-1:0]  lba_o,
	output logic                        last_o
);

	always_ff @(posedge clk_sys) begin
		if (reset || start_i)
			lba_o <= '0;  // every transfer begins at sector 0
		else if (step_i)
			lba_o <= lba_o + 1'b1;
	end

	assign last_o = (lba_o == file_mask_i);

endmodule

// File: rtl/backup_fsm.sv
// backup ram load and save sequencer with storage request handshake and pending save tracking
`timescale 1ns/1ns

module backup_fsm (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active_i,
	input  logic                  img_mounted_i,
	input  logic                  img_readonly_i,
	input  logic                  img_nonzero_i,
	input  logic                  load_req_i,
	input  logic                  save_req_i,
	input  logic                  osd_status_i,
	input  logic                  autosave_en_i,
	input  logic                  cram_wr_i,
	input  cart_pkg::cart_info_t  info_i,
	input  logic                  sd_ack_i,
	input  logic                  last_i,
	output logic                  sd_rd_o,
	output logic                  sd_wr_o,
	output logic                  busy_o,
	output logic                  sav_pending_o,
	output logic                  start_o,
	output logic                  step_o
);

	typedef enum logic [1:0] {
		st_idle,
		st_request,   // request level up, waiting for ack
		st_transfer,  // sector streaming while ack high
		st_next       // advance to the next sector
	} state_e;

	state_e state;
	logic   bk_ena;    // a writable image is mounted
	logic   loading;   // direction of the running transfer
	logic   old_dl;
	logic   old_load;
	logic   old_save;
	logic   autosave;
	logic   load_go;
	logic   save_go;

	assign autosave = sav_pending_o & osd_status_i & autosave_en_i;
	assign load_go  = bk_ena & ((load_req_i & ~old_load) |
		(old_dl & ~dl_active_i & img_nonzero_i));  // end of download reloads
	assign save_go  = bk_ena & (save_req_i | autosave) & ~old_save;

	assign start_o = (state == st_idle) & (load_go | save_go);
	assign step_o  = (state == st_next);
	assign busy_o  = (state != st_idle);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state         <= st_idle;
			bk_ena        <= 1'b0;
			loading       <= 1'b0;
			old_dl        <= 1'b0;
			old_load      <= 1'b0;
			old_save      <= 1'b0;
			sd_rd_o       <= 1'b0;
			sd_wr_o       <= 1'b0;
			sav_pending_o <= 1'b0;
		end else begin
			old_dl   <= dl_active_i;
			old_load <= load_req_i;
			old_save <= save_req_i | autosave;

			if (!old_dl && dl_active_i) bk_ena <= 1'b0;  // new cartridge
			if (dl_active_i && img_mounted_i && !img_readonly_i) bk_ena <= 1'b1;

			if (cram_wr_i && !osd_status_i && info_i.save_ok)
				sav_pending_o <= 1'b1;
			else if (start_o)
				sav_pending_o <= 1'b0;

			case (state)
				st_idle:
					if (start_o) begin
						loading <= load_go;  // load wins over save
						sd_rd_o <= load_go;
						sd_wr_o <= ~load_go;
						state   <= st_request;
					end
				st_request:
					if (sd_ack_i) begin
						sd_rd_o <= 1'b0;
						sd_wr_o <= 1'b0;
						state   <= st_transfer;
					end
				st_transfer:
					if (!sd_ack_i) state <= last_i ? st_idle : st_next;
				st_next: begin
					sd_rd_o <= loading;
					sd_wr_o <= ~loading;
					state   <= st_request;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: rtl/cart_ram.sv
// cartridge ram, two byte lanes on one word address, cpu port and backup port
`timescale 1ns/1ns

module cart_ram (
	input  logic                               clk_sys,
	input  cart_pkg::cpu_addr_u                cart_addr_i,
	input  logic                               cart_rd_i,
	input  logic                               cart_wr_i,  // already qualified by region
	input  logic [7:0]                         cart_di_i,
	input  logic [cart_pkg::cram_addr_w-1:0]   cram_addr_i,
	input  cart_pkg::bank_state_t              bank_i,
	input  cart_pkg::cart_info_t               info_i,
	input  logic [7:0]                         sd_buff_addr_i,
	input  logic [cart_pkg::lba_w-1:0]         sd_lba_i,
	input  logic [15:0]                        sd_buff_dout_i,
	input  logic                               sd_buff_wr_i,
	input  logic                               sd_ack_i,
	output logic [7:0]                         cart_do_o,
	output logic [15:0]                        sd_buff_din_o
);

	logic [1:0][7:0] mem [1 << (cart_pkg::cram_addr_w - 1)];  // hi lane, lo lane
	logic [15:0]     cpu_waddr;
	logic [15:0]     bk_addr;
	logic [7:0]      cpu_q;
	logic            rd_cram;    // read hit a000-bfff
	logic            rd_ena;
	logic            rd_rtc;
	logic            rd_nibble;  // mbc2 internal 4-bit ram

	assign cpu_waddr = cram_addr_i[cart_pkg::cram_addr_w-1:1];
	assign bk_addr   = {sd_lba_i, sd_buff_addr_i};  // sector, word in sector

	always_ff @(posedge clk_sys) begin
		if (cart_wr_i)
			mem[cpu_waddr][cram_addr_i[0]] <= cart_di_i;
		if (sd_buff_wr_i && sd_ack_i)
			mem[bk_addr] <= sd_buff_dout_i;
		sd_buff_din_o <= mem[bk_addr];

		// capture data and read decode together so cart_do_o holds until next read
		if (cart_rd_i) begin
			cpu_q     <= mem[cpu_waddr][cram_addr_i[0]];
			rd_cram   <= cart_addr_i.rgn.region == cart_pkg::region_cram;
			rd_ena    <= bank_i.ram_enable;
			rd_rtc    <= bank_i.rtc_mode;
			rd_nibble <= info_i.kind == cart_pkg::mbc2 &&
				cart_addr_i.rgn.offset[12:9] == 4'd0;  // a000-a1ff
		end
	end

	always_comb begin
		if (!rd_cram)       cart_do_o = 8'h00;  // rom data comes from outside
		else if (!rd_ena)   cart_do_o = 8'hFF;  // disabled ram floats high
		else if (rd_nibble) cart_do_o = {4'hF, cpu_q[3:0]};
		else if (rd_rtc)    cart_do_o = 8'h00;  // rtc registers not kept
		else                cart_do_o = cpu_q;
	end

endmodule

// File: rtl/mbc_regs.sv
// mapper bank registers written by the cpu, rom byte address and cartridge ram address forming
`timescale 1ns/1ns

module mbc_regs (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 dl_active_i,
	input  cart_pkg::cpu_addr_u                  cart_addr_i,
	input  logic                                 cart_wr_i,
	input  logic [7:0]                           cart_di_i,
	input  cart_pkg::cart_info_t                 info_i,
	output cart_pkg::bank_state_t                bank_o,
	output logic [cart_pkg::rom_bank_w+13:0]     rom_addr_o,
	output logic [cart_pkg::cram_addr_w-1:0]     cram_addr_o
);

	cart_pkg::bank_state_t                bank_q;
	logic [cart_pkg::rom_bank_w-1:0]      rom_sel;
	logic [cart_pkg::ram_bank_w-1:0]      ram_sel;
	logic [2:0]                           region;

	assign region = cart_addr_i.rgn.region;

	// ------------------------------------------------------------------------
	// register writes
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active_i) begin
			bank_q          <= '0;
			bank_q.rom_bank <= 9'd1;  // bank 1 in the switchable window
		end else if (cart_wr_i) begin
			case (region)
				cart_pkg::region_rom_bank: begin
					if (info_i.kind == cart_pkg::mbc5) begin
						if ({region[0], cart_addr_i.rgn.offset[12]} == 2'b11)
							bank_q.rom_bank[8] <= cart_di_i[0];      // 3000-3fff
						else
							bank_q.rom_bank[7:0] <= cart_di_i;       // 2000-2fff
					end else if (cart_di_i[6:0] == 7'd0) begin
						bank_q.rom_bank <= 9'd1;  // mbc1-3 never map bank 0 here
					end else begin
						bank_q.rom_bank <= {2'b00, cart_di_i[6:0]};
					end
				end
				cart_pkg::region_ram_bank: begin
					if (info_i.kind == cart_pkg::mbc3) begin
						bank_q.rtc_mode <= cart_di_i[3];  // 08-0c select rtc
						if (!cart_di_i[3])
							bank_q.ram_bank <= {2'b00, cart_di_i[1:0]};
					end else if (info_i.kind == cart_pkg::mbc5) begin
						bank_q.ram_bank <= cart_di_i[3:0];
					end else begin
						bank_q.ram_bank <= {2'b00, cart_di_i[1:0]};
					end
				end
				cart_pkg::region_mode:
					if (info_i.kind == cart_pkg::mbc1) bank_q.mbc1_mode <= cart_di_i[0];
				cart_pkg::region_rom_en:
					bank_q.ram_enable <= (cart_di_i[3:0] == cart_pkg::ram_enable_key);
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// address forming
	// ------------------------------------------------------------------------
	always_comb begin
		rom_sel = bank_q.rom_bank;
		if (info_i.kind == cart_pkg::mbc1)  // mode 0 lends ram bank bits as rom 6:5
			rom_sel = {2'b00, bank_q.mbc1_mode ? 2'b00 : bank_q.ram_bank[1:0],
				bank_q.rom_bank[4:0]};
		rom_sel = rom_sel & info_i.rom_mask;  // mirror small roms
		if (info_i.kind == cart_pkg::mbc_none)
			rom_sel = 9'd1;
		if (cart_addr_i.rom.quadrant == 2'b00)
			rom_sel = '0;  // fixed bank 0 at 0000-3fff

		ram_sel = bank_q.ram_bank & info_i.ram_mask;
		if (info_i.kind == cart_pkg::mbc_none ||
				(info_i.kind == cart_pkg::mbc1 && !bank_q.mbc1_mode))
			ram_sel = '0;  // unbanked ram
	end

	assign rom_addr_o  = {rom_sel, cart_addr_i.rom.bank_lsb, cart_addr_i.rom.offset};
	assign cram_addr_o = {ram_sel, cart_addr_i.rgn.offset};
	assign bank_o      = bank_q;

endmodule

// File: rtl/cart_header.sv
// cartridge header capture from the download stream and decode of mapper, masks and battery
`timescale 1ns/1ns

module cart_header (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_active_i,
	input  logic                    dl_wr_i,
	input  logic [24:0]             dl_addr_i,
	input  logic [15:0]             dl_data_i,
	output cart_pkg::cart_info_t    info_o
);

	logic [7:0] type_q;
	logic [7:0] rom_size_q;
	logic [7:0] ram_size_q;
	logic       battery;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_q     <= '0;
			rom_size_q <= '0;
			ram_size_q <= '0;
		end else if (dl_active_i && dl_wr_i) begin
			if (dl_addr_i == 25'(cart_pkg::hdr_type_addr))
				type_q <= dl_data_i[15:8];  // 0x147 sits in the high byte
			if (dl_addr_i == 25'(cart_pkg::hdr_size_addr))
				{ram_size_q, rom_size_q} <= dl_data_i;
		end
	end

	assign battery = type_q inside {8'h03, 8'h06, 8'h09, 8'h0D, 8'h10,
		8'h13, 8'h1B, 8'h1E, 8'h22, 8'hFF};

	// ------------------------------------------------------------------------
	// header decode
	// ------------------------------------------------------------------------
	always_comb begin
		case (type_q) inside
			[8'h01:8'h03]: info_o.kind = cart_pkg::mbc1;
			[8'h05:8'h06]: info_o.kind = cart_pkg::mbc2;
			[8'h0F:8'h13]: info_o.kind = cart_pkg::mbc3;
			[8'h19:8'h1E]: info_o.kind = cart_pkg::mbc5;
			default:       info_o.kind = cart_pkg::mbc_none;  // 32k plain rom
		endcase

		// 2^(n+1) banks for sizes 0..8, odd sizes 0x52-0x54 mirror as 128
		if (rom_size_q <= 8'd8)
			info_o.rom_mask = 9'h1FF >> (4'd8 - rom_size_q[3:0]);
		else
			info_o.rom_mask = 9'd127;

		if (ram_size_q < 8'd3)       info_o.ram_mask = 4'd0;   // one 8k bank at most
		else if (ram_size_q == 8'd3) info_o.ram_mask = 4'd3;   // 32k
		else                         info_o.ram_mask = 4'd15;  // 128k

		if (info_o.kind == cart_pkg::mbc2) info_o.file_mask = 8'h01;  // 512x4 bits
		else if (ram_size_q == 8'd1)      info_o.file_mask = 8'h03;
		else if (ram_size_q == 8'd2)      info_o.file_mask = 8'h0F;
		else if (ram_size_q == 8'd3)      info_o.file_mask = 8'h3F;
		else                              info_o.file_mask = 8'hFF;

		info_o.save_ok = battery && (ram_size_q != 8'd0 || info_o.kind == cart_pkg::mbc2);
	end

endmodule

// File: rtl/cart_pkg.sv
// cartridge mapper shared types: header offsets, mapper kinds, register regions, bank state
package cart_pkg;

	// ------------------------------------------------------------------------
	// download header offsets (word addresses)
	// ------------------------------------------------------------------------
	localparam logic [15:0] hdr_type_addr = 16'h0146;  // mapper type in high byte
	localparam logic [15:0] hdr_size_addr = 16'h0148;  // ram size high, rom size low

	// cpu address bits 15:13 regions
	localparam logic [2:0] region_rom_en   = 3'b000;  // 0000-1fff ram enable
	localparam logic [2:0] region_rom_bank = 3'b001;  // 2000-3fff rom bank
	localparam logic [2:0] region_ram_bank = 3'b010;  // 4000-5fff ram bank / rtc select
	localparam logic [2:0] region_mode     = 3'b011;  // 6000-7fff mbc1 mode
	localparam logic [2:0] region_cram     = 3'b101;  // a000-bfff cartridge ram

	localparam logic [3:0] ram_enable_key = 4'hA;

	localparam int rom_bank_w  = 9;   // up to 512 banks on mbc5
	localparam int ram_bank_w  = 4;   // up to 16 banks of 8k
	localparam int cram_addr_w = 17;  // 128k bytes
	localparam int lba_w       = 8;   // 256 sectors of 512 bytes

	typedef enum logic [2:0] {
		mbc_none,
		mbc1,
		mbc2,
		mbc3,
		mbc5
	} mbc_kind_e;

	// decoded header, fixed for the whole run of a cartridge
	typedef struct packed {
		mbc_kind_e             kind;
		logic [rom_bank_w-1:0] rom_mask;
		logic [ram_bank_w-1:0] ram_mask;
		logic [lba_w-1:0]      file_mask;  // index of the last backup sector
		logic                  save_ok;    // battery and something to save
	} cart_info_t;

	// mapper registers as set by the cpu
	typedef struct packed {
		logic [rom_bank_w-1:0] rom_bank;
		logic [ram_bank_w-1:0] ram_bank;
		logic                  mbc1_mode;
		logic                  rtc_mode;  // mbc3 rtc mapped at a000
		logic                  ram_enable;
	} bank_state_t;

	// two views of the cpu address
	typedef union packed {
		struct packed {
			logic [1:0]  quadrant;  // 16k window
			logic        bank_lsb;
			logic [12:0] offset;
		} rom;
		struct packed {
			logic [2:0]  region;  // 8k region
			logic [12:0] offset;
		} rgn;
	} cpu_addr_u;

endpackage
